/* compile.f */
+incdir+source
+incdir+verification
source/mmu_pkg.sv
source/tlb_search_if.sv
source/addr_trans.sv
source/tlb.sv
source/cache_req_gen.sv
source/mmu.sv
verification/tb_mmu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the MMU testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f compile.f --top-module tb_mmu -o sim_mmu &&
./obj_dir/sim_mmu | tee /dev/stderr | grep -q "STATUS: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* source/addr_trans.sv */
`timescale 1ns/1ps

module addr_trans (
    input  logic                   i_da,
    input  logic [1:0]             i_da_mat,
    input  logic [1:0]             i_plv,
    input  logic [9:0]             i_asid,
    input  mmu_pkg::dmw_t          i_dmw0,
    input  mmu_pkg::dmw_t          i_dmw1,
    input  logic [31:0]            i_va,
    tlb_search_if.requester        srch,
    output logic [31:0]            o_pa,
    output logic [1:0]             o_mat,
    output logic                   o_tlb_miss,
    output logic                   o_page_invalid,
    output logic                   o_plv_fault,
    output logic                   o_page_clean
);
    import mmu_pkg::*;

    va_u  va;
    logic dmw0_hit;
    logic dmw1_hit;
    logic use_tlb;
    logic page_ok;

    function automatic logic dmw_match(input dmw_t w, input logic [1:0] plv,
                                       input logic [2:0] vseg);
        return (w.vseg == vseg) && ((plv == 2'd0 && w.plv0) || (plv == 2'd3 && w.plv3));
    endfunction

    assign va       = i_va;
    assign dmw0_hit = dmw_match(i_dmw0, i_plv, va.window.vseg);
    assign dmw1_hit = dmw_match(i_dmw1, i_plv, va.window.vseg);
    assign use_tlb  = !i_da && !dmw0_hit && !dmw1_hit;

    // the query goes out every cycle, its result only matters on the paged path
    assign srch.vppn     = va.paged.vppn;
    assign srch.va_bit12 = va.paged.va_bit12;
    assign srch.asid     = i_asid;

    always_comb begin
        if (i_da) begin
            o_pa  = i_va;
            o_mat = i_da_mat;
        end else if (dmw0_hit) begin
            o_pa  = {i_dmw0.pseg, va.window.offset};
            o_mat = i_dmw0.mat;
        end else if (dmw1_hit) begin
            o_pa  = {i_dmw1.pseg, va.window.offset};
            o_mat = i_dmw1.mat;
        end else begin
            o_pa  = {srch.result.ppn, va.paged.offset};
            o_mat = srch.result.mat;
        end
    end

    // each flag below implies the ones above it were clear
    assign page_ok        = use_tlb && srch.result.found && srch.result.v;
    assign o_tlb_miss     = use_tlb && !srch.result.found;
    assign o_page_invalid = use_tlb && srch.result.found && !srch.result.v;
    assign o_plv_fault    = page_ok && (i_plv > srch.result.plv);
    assign o_page_clean   = page_ok && !o_plv_fault && !srch.result.d;

endmodule

/* source/cache_req_gen.sv */
`timescale 1ns/1ps
`include "mmu_consts.svh"

module cache_req_gen (
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic        i_fetch_valid,
    input  logic [31:0] i_fetch_va,
    input  logic        i_data_valid,
    input  logic        i_data_we,
    input  logic [1:0]  i_data_size,
    input  logic [3:0]  i_data_wstrb,
    input  logic [31:0] i_data_wdata,
    input  logic [31:0] i_fetch_pa,
    input  logic [1:0]  i_fetch_mat,
    input  logic        i_fetch_tlb_miss,
    input  logic        i_fetch_page_invalid,
    input  logic        i_fetch_plv_fault,
    input  logic [31:0] i_data_pa,
    input  logic [1:0]  i_data_mat,
    input  logic        i_data_tlb_miss,
    input  logic        i_data_page_invalid,
    input  logic        i_data_plv_fault,
    input  logic        i_data_page_clean,
    input  logic        i_icache_addr_ok,
    input  logic        i_icache_data_ok,
    input  logic [63:0] i_icache_rdata,
    input  logic        i_dcache_addr_ok,
    input  logic        i_dcache_data_ok,
    input  logic [31:0] i_dcache_rdata,
    output logic        o_fetch_addr_ok,
    output logic        o_fetch_double,
    output logic        o_fetch_data_ok,
    output logic [63:0] o_fetch_rdata,
    output logic        o_fetch_tlbr,
    output logic        o_fetch_pif,
    output logic        o_fetch_ppi,
    output logic        o_data_addr_ok,
    output logic        o_data_data_ok,
    output logic [31:0] o_data_rdata,
    output logic        o_data_tlbr,
    output logic        o_data_pil,
    output logic        o_data_pis,
    output logic        o_data_ppi,
    output logic        o_data_pme,
    output logic        o_icache_req,
    output logic [31:0] o_icache_addr,
    output logic        o_icache_uncached,
    output logic        o_dcache_req,
    output logic        o_dcache_wr,
    output logic [1:0]  o_dcache_size,
    output logic [3:0]  o_dcache_wstrb,
    output logic [31:0] o_dcache_addr,
    output logic [31:0] o_dcache_wdata,
    output logic        o_dcache_uncached
);

    assign o_icache_req      = i_fetch_valid;
    assign o_icache_addr     = i_fetch_pa;
    assign o_icache_uncached = i_fetch_mat == 2'd0;
    assign o_fetch_addr_ok   = i_icache_addr_ok;
    assign o_fetch_data_ok   = i_icache_data_ok;
    assign o_fetch_rdata     = i_icache_rdata;

    // a 64-bit fetch must not run past the end of the line
    assign o_fetch_double = (i_fetch_mat == 2'd1)
                            && (i_fetch_va[`OFFSET_WIDTH-1:2] != {(`OFFSET_WIDTH-2){1'b1}});

    assign o_fetch_tlbr = i_fetch_valid && i_fetch_tlb_miss;
    assign o_fetch_pif  = i_fetch_valid && i_fetch_page_invalid;
    assign o_fetch_ppi  = i_fetch_valid && i_fetch_plv_fault;

    assign o_dcache_req      = i_data_valid;
    assign o_dcache_wr       = i_data_we;
    assign o_dcache_size     = i_data_size;
    assign o_dcache_wstrb    = i_data_wstrb;
    assign o_dcache_addr     = i_data_pa;
    assign o_dcache_wdata    = i_data_wdata;
    assign o_dcache_uncached = i_data_mat == 2'd0;
    assign o_data_addr_ok    = i_dcache_addr_ok;
    assign o_data_data_ok    = i_dcache_data_ok;
    assign o_data_rdata      = i_dcache_rdata;

    assign o_data_tlbr = i_data_valid && i_data_tlb_miss;
    assign o_data_pil  = i_data_valid && i_data_page_invalid && !i_data_we;
    assign o_data_pis  = i_data_valid && i_data_page_invalid && i_data_we;
    assign o_data_ppi  = i_data_valid && i_data_plv_fault;
    assign o_data_pme  = i_data_valid && i_data_page_clean && i_data_we;     // clean page only faults on a store

    a_store_wstrb: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_data_valid && i_data_we) |-> (i_data_wstrb != 4'd0));

endmodule

/* source/mmu.sv */
`timescale 1ns/1ps
`include "mmu_consts.svh"

module mmu (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_da,
    input  logic [1:0]             i_datf,
    input  logic [1:0]             i_datm,
    input  logic [1:0]             i_plv,
    input  logic [9:0]             i_asid,
    input  mmu_pkg::dmw_t          i_dmw0,
    input  mmu_pkg::dmw_t          i_dmw1,
    input  logic                   i_fetch_valid,
    input  logic [31:0]            i_fetch_va,
    input  logic                   i_data_valid,
    input  logic [31:0]            i_data_va,
    input  logic                   i_data_we,
    input  logic [1:0]             i_data_size,
    input  logic [3:0]             i_data_wstrb,
    input  logic [31:0]            i_data_wdata,
    input  logic                   i_invtlb_valid,
    input  logic [4:0]             i_invtlb_op,
    input  logic [9:0]             i_invtlb_asid,
    input  logic [31:0]            i_invtlb_va,
    input  logic                   i_tlb_we,
    input  logic [`TLB_IDX_W-1:0]  i_tlb_w_index,
    input  mmu_pkg::tlb_entry_t    i_tlb_w_entry,
    input  logic [`TLB_IDX_W-1:0]  i_tlb_r_index,
    input  logic                   i_tlbsrch_valid,
    input  logic [18:0]            i_tlbsrch_vppn,
    input  logic                   i_icache_addr_ok,
    input  logic                   i_icache_data_ok,
    input  logic [63:0]            i_icache_rdata,
    input  logic                   i_dcache_addr_ok,
    input  logic                   i_dcache_data_ok,
    input  logic [31:0]            i_dcache_rdata,
    output logic                   o_fetch_addr_ok,
    output logic                   o_fetch_double,
    output logic                   o_fetch_data_ok,
    output logic [63:0]            o_fetch_rdata,
    output logic                   o_fetch_tlbr,
    output logic                   o_fetch_pif,
    output logic                   o_fetch_ppi,
    output logic                   o_data_addr_ok,
    output logic                   o_data_data_ok,
    output logic [31:0]            o_data_rdata,
    output logic                   o_data_tlbr,
    output logic                   o_data_pil,
    output logic                   o_data_pis,
    output logic                   o_data_ppi,
    output logic                   o_data_pme,
    output mmu_pkg::tlb_entry_t    o_tlb_r_entry,
    output logic                   o_tlbsrch_found,
    output logic [`TLB_IDX_W-1:0]  o_tlbsrch_index,
    output logic                   o_icache_req,
    output logic [31:0]            o_icache_addr,
    output logic                   o_icache_uncached,
    output logic                   o_dcache_req,
    output logic                   o_dcache_wr,
    output logic [1:0]             o_dcache_size,
    output logic [3:0]             o_dcache_wstrb,
    output logic [31:0]            o_dcache_addr,
    output logic [31:0]            o_dcache_wdata,
    output logic                   o_dcache_uncached
);

    logic [31:0] fetch_pa;
    logic [1:0]  fetch_mat;
    logic        fetch_tlb_miss;
    logic        fetch_page_invalid;
    logic        fetch_plv_fault;
    logic [31:0] data_pa;
    logic [1:0]  data_mat;
    logic        data_tlb_miss;
    logic        data_page_invalid;
    logic        data_plv_fault;
    logic        data_page_clean;

    tlb_search_if fetch_srch ();
    tlb_search_if data_srch ();

    addr_trans fetch_trans_i (
        .*,
        .i_da_mat       (i_datf),
        .i_va           (i_fetch_va),
        .srch           (fetch_srch),
        .o_pa           (fetch_pa),
        .o_mat          (fetch_mat),
        .o_tlb_miss     (fetch_tlb_miss),
        .o_page_invalid (fetch_page_invalid),
        .o_plv_fault    (fetch_plv_fault),
        .o_page_clean   ()                  // fetches never write
    );

    addr_trans data_trans_i (
        .*,
        .i_da_mat       (i_datm),
        .i_va           (i_data_va),
        .srch           (data_srch),
        .o_pa           (data_pa),
        .o_mat          (data_mat),
        .o_tlb_miss     (data_tlb_miss),
        .o_page_invalid (data_page_invalid),
        .o_plv_fault    (data_plv_fault),
        .o_page_clean   (data_page_clean)
    );

    tlb tlb_i (
        .*,
        .i_we         (i_tlb_we),
        .i_w_index    (i_tlb_w_index),
        .i_w_entry    (i_tlb_w_entry),
        .i_r_index    (i_tlb_r_index),
        .o_r_entry    (o_tlb_r_entry),
        .o_srch_found (o_tlbsrch_found),
        .o_srch_index (o_tlbsrch_index)
    );

    cache_req_gen cache_req_gen_i (
        .*,
        .i_fetch_pa           (fetch_pa),
        .i_fetch_mat          (fetch_mat),
        .i_fetch_tlb_miss     (fetch_tlb_miss),
        .i_fetch_page_invalid (fetch_page_invalid),
        .i_fetch_plv_fault    (fetch_plv_fault),
        .i_data_pa            (data_pa),
        .i_data_mat           (data_mat),
        .i_data_tlb_miss      (data_tlb_miss),
        .i_data_page_invalid  (data_page_invalid),
        .i_data_plv_fault     (data_plv_fault),
        .i_data_page_clean    (data_page_clean)
    );

endmodule

/* source/mmu_consts.svh */
`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

// TLB size, 8, 16 or 32 entries
`define TLB_ENTRIES 16

// log2 of TLB_ENTRIES
`define TLB_IDX_W 4

// 16-byte cache lines
`define OFFSET_WIDTH 4

`endif

/* source/mmu_pkg.sv */
`include "mmu_consts.svh"

package mmu_pkg;

    typedef struct packed {
        logic       plv0;
        logic       plv3;
        logic [1:0] mat;
        logic [2:0] pseg;
        logic [2:0] vseg;
    } dmw_t;

    typedef struct packed {
        logic [19:0] ppn;
        logic [1:0]  plv;
        logic [1:0]  mat;
        logic        d;
        logic        v;
    } tlb_page_t;

    typedef struct packed {
        logic [18:0] vppn;
        logic        g;
        logic [9:0]  asid;
        logic        e;
        tlb_page_t   p0;                    // even 4 KB page
        tlb_page_t   p1;                    // odd 4 KB page
    } tlb_entry_t;

    typedef struct packed {
        logic                  found;
        logic [`TLB_IDX_W-1:0] index;
        logic [19:0]           ppn;
        logic [1:0]            plv;
        logic [1:0]            mat;
        logic                  d;
        logic                  v;
    } tlb_result_t;

    typedef union packed {
        struct packed {
            logic [18:0] vppn;
            logic        va_bit12;
            logic [11:0] offset;
        } paged;
        struct packed {
            logic [2:0]  vseg;
            logic [28:0] offset;
        } window;
    } va_u;

endpackage

/* source/tlb.sv */
`timescale 1ns/1ps
`include "mmu_consts.svh"

module tlb (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_data_valid,
    input  logic                   i_tlbsrch_valid,
    input  logic [18:0]            i_tlbsrch_vppn,
    input  logic                   i_invtlb_valid,
    input  logic [4:0]             i_invtlb_op,
    input  logic [9:0]             i_invtlb_asid,
    input  logic [31:0]            i_invtlb_va,
    input  logic                   i_we,
    input  logic [`TLB_IDX_W-1:0]  i_w_index,
    input  mmu_pkg::tlb_entry_t    i_w_entry,
    input  logic [`TLB_IDX_W-1:0]  i_r_index,
    output mmu_pkg::tlb_entry_t    o_r_entry,
    output logic                   o_srch_found,
    output logic [`TLB_IDX_W-1:0]  o_srch_index,
    tlb_search_if.responder        fetch_srch,
    tlb_search_if.responder        data_srch
);
    import mmu_pkg::*;

    tlb_entry_t              entries [`TLB_ENTRIES];
    logic [`TLB_ENTRIES-1:0] e_q;           // the live e bits, the copy in entries is shadowed
    logic [`TLB_ENTRIES-1:0] fetch_hits;
    logic [`TLB_ENTRIES-1:0] data_hits;
    logic [`TLB_ENTRIES-1:0] inv_hits;
    logic [18:0]             data_vppn;
    logic [18:0]             inv_vppn;

    function automatic logic [`TLB_ENTRIES-1:0] match(input logic [18:0] vppn,
                                                      input logic [9:0] asid);
        logic [`TLB_ENTRIES-1:0] hits;
        hits = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            hits[i] = e_q[i] && (entries[i].vppn == vppn)
                      && (entries[i].g || entries[i].asid == asid);
        end
        return hits;
    endfunction

    function automatic tlb_result_t pick(input logic [`TLB_ENTRIES-1:0] hits, input logic odd);
        tlb_result_t res;
        tlb_page_t   pg;
        res = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (hits[i]) begin
                pg        = odd ? entries[i].p1 : entries[i].p0;
                res.found = 1'b1;
                res.index = i[`TLB_IDX_W-1:0];
                res.ppn   = pg.ppn;
                res.plv   = pg.plv;
                res.mat   = pg.mat;
                res.d     = pg.d;
                res.v     = pg.v;
            end
        end
        return res;
    endfunction

    assign data_vppn = i_tlbsrch_valid ? i_tlbsrch_vppn : data_srch.vppn;

    always_comb begin
        fetch_hits        = match(fetch_srch.vppn, fetch_srch.asid);
        data_hits         = match(data_vppn, data_srch.asid);
        fetch_srch.result = pick(fetch_hits, fetch_srch.va_bit12);
        data_srch.result  = pick(data_hits, data_srch.va_bit12);
    end

    assign o_srch_found = i_tlbsrch_valid && data_srch.result.found;
    assign o_srch_index = data_srch.result.index;

    always_comb begin
        o_r_entry   = entries[i_r_index];
        o_r_entry.e = e_q[i_r_index];
    end

    assign inv_vppn = i_invtlb_va[31:13];

    always_comb begin
        logic asid_eq;
        logic vppn_eq;
        inv_hits = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            asid_eq = entries[i].asid == i_invtlb_asid;
            vppn_eq = entries[i].vppn == inv_vppn;
            case (i_invtlb_op)
                5'd0, 5'd1: inv_hits[i] = 1'b1;
                5'd2:       inv_hits[i] = entries[i].g;
                5'd3:       inv_hits[i] = !entries[i].g;
                5'd4:       inv_hits[i] = !entries[i].g && asid_eq;
                5'd5:       inv_hits[i] = !entries[i].g && asid_eq && vppn_eq;
                5'd6:       inv_hits[i] = (entries[i].g || asid_eq) && vppn_eq;
                default:    inv_hits[i] = 1'b0;
            endcase
        end
    end

    // INVTLB and TLBWR come from different instructions and never share a cycle
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            e_q <= '0;
        end else if (i_invtlb_valid) begin
            e_q <= e_q & ~inv_hits;
        end else if (i_we) begin
            e_q[i_w_index] <= i_w_entry.e;
        end
    end

    always_ff @(posedge clk) begin
        if (i_we) begin
            entries[i_w_index] <= i_w_entry;
        end
    end

    a_invtlb_op: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_invtlb_valid |-> i_invtlb_op <= 5'd6);

    // software must never leave two live entries covering one page
    a_single_hit: assert property (@(posedge clk) disable iff (!i_rst_n)
        $onehot0(fetch_hits) && $onehot0(data_hits));

    a_srch_vs_data: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_data_valid && i_tlbsrch_valid));

endmodule

/* source/tlb_search_if.sv */
`timescale 1ns/1ps

interface tlb_search_if;
    import mmu_pkg::*;

    logic [18:0] vppn;
    logic        va_bit12;                  // picks the odd half of the entry
    logic [9:0]  asid;
    tlb_result_t result;

    modport requester (
        output vppn,
        output va_bit12,
        output asid,
        input  result
    );

    modport responder (
        input  vppn,
        input  va_bit12,
        input  asid,
        output result
    );

endinterface

/* verification/mmu_tb_cases.svh */
`ifndef MMU_TB_CASES_SVH
`define MMU_TB_CASES_SVH

// each row holds name, mode {da, dmw on, data port, we}, plv, asid, va, pa checked, pa
// and flags {uncached, double, tlbr, pif, pil, pis, ppi, pme}
typedef struct packed {
    logic [127:0] name;
    logic [3:0]   mode;
    logic [1:0]   plv;
    logic [9:0]   asid;
    logic [31:0]  va;
    logic         chk_pa;
    logic [31:0]  pa;
    logic [7:0]   flags;
} case_t;

localparam int NUM_CASES = 20;

localparam case_t CASES [NUM_CASES] = '{
    '{"da_fetch",   4'b1000, 2'd0, 10'd5, 32'h1234_5678, 1'b1, 32'h1234_5678, 8'b01_000000},
    '{"da_load",    4'b1010, 2'd0, 10'd5, 32'h8765_4320, 1'b1, 32'h8765_4320, 8'b10_000000},
    '{"dmw0_fetch", 4'b0100, 2'd0, 10'd5, 32'h8000_1004, 1'b1, 32'h0000_1004, 8'b01_000000},
    '{"dmw1_plv3",  4'b0110, 2'd3, 10'd5, 32'h8000_1004, 1'b1, 32'h2000_1004, 8'b10_000000},
    '{"dmw_prio",   4'b0110, 2'd0, 10'd5, 32'h9000_0000, 1'b1, 32'h1000_0000, 8'b00_000000},
    '{"tlb_even",   4'b0000, 2'd3, 10'd5, 32'h0002_0abc, 1'b1, 32'h1234_5abc, 8'b00_000000},
    '{"tlb_odd",    4'b0010, 2'd3, 10'd5, 32'h0002_1010, 1'b1, 32'h2222_2010, 8'b10_000000},
    '{"tlb_global", 4'b0010, 2'd3, 10'd9, 32'h0004_0008, 1'b1, 32'h3333_3008, 8'b00_000000},
    '{"asid_miss",  4'b0000, 2'd3, 10'd9, 32'h0002_0000, 1'b0, 32'h0,         8'b00_100000},
    '{"refill",     4'b0010, 2'd3, 10'd5, 32'h0010_0000, 1'b0, 32'h0,         8'b00_100000},
    '{"pif",        4'b0000, 2'd3, 10'd5, 32'h0004_1000, 1'b0, 32'h0,         8'b01_010000},
    '{"pil",        4'b0010, 2'd3, 10'd5, 32'h0004_1000, 1'b0, 32'h0,         8'b00_001000},
    '{"pis",        4'b0011, 2'd3, 10'd5, 32'h0004_1000, 1'b0, 32'h0,         8'b00_000100},
    '{"ppi",        4'b0010, 2'd3, 10'd5, 32'h0006_0000, 1'b0, 32'h0,         8'b00_000010},
    '{"pme",        4'b0011, 2'd3, 10'd5, 32'h0004_0000, 1'b1, 32'h3333_3000, 8'b00_000001},
    '{"store_ok",   4'b0011, 2'd3, 10'd5, 32'h0006_1004, 1'b1, 32'h6666_6004, 8'b00_000000},
    '{"dbl_w0",     4'b0000, 2'd3, 10'd5, 32'h0002_0000, 1'b1, 32'h1234_5000, 8'b01_000000},
    '{"dbl_w1",     4'b0000, 2'd3, 10'd5, 32'h0002_0004, 1'b1, 32'h1234_5004, 8'b01_000000},
    '{"dbl_w2",     4'b0000, 2'd3, 10'd5, 32'h0002_0008, 1'b1, 32'h1234_5008, 8'b01_000000},
    '{"dbl_unc",    4'b0000, 2'd3, 10'd5, 32'h0002_1004, 1'b1, 32'h2222_2004, 8'b10_000000}
};

// entry 1 is global, its odd half is invalid and its even half is clean
localparam tlb_entry_t PRELOAD [4] = '{
    '{19'h00010, 1'b0, 10'd5, 1'b1, '{20'h12345, 2'd3, 2'd1, 1'b1, 1'b1},
                                    '{20'h22222, 2'd3, 2'd0, 1'b1, 1'b1}},
    '{19'h00020, 1'b1, 10'h3ff, 1'b1, '{20'h33333, 2'd3, 2'd1, 1'b0, 1'b1},
                                      '{20'h44444, 2'd3, 2'd1, 1'b1, 1'b0}},
    '{19'h00030, 1'b0, 10'd5, 1'b1, '{20'h55555, 2'd0, 2'd1, 1'b1, 1'b1},
                                    '{20'h66666, 2'd3, 2'd1, 1'b1, 1'b1}},
    '{19'h00040, 1'b0, 10'd7, 1'b1, '{20'h77777, 2'd3, 2'd1, 1'b1, 1'b1},
                                    '{20'h78888, 2'd3, 2'd1, 1'b1, 1'b1}}
};

`endif

/* verification/tb_mmu.sv */
`timescale 1ns/1ps
`include "mmu_consts.svh"

module tb_mmu;
    import mmu_pkg::*;

    `include "mmu_tb_cases.svh"

    localparam dmw_t DMW_A = '{1'b1, 1'b0, 2'd1, 3'd0, 3'd4};    // plv0 only, cached
    localparam dmw_t DMW_B = '{1'b1, 1'b1, 2'd0, 3'd1, 3'd4};    // any plv, uncached
    localparam int TIMEOUT = 20;

    logic clk, i_rst_n, i_da, i_fetch_valid, i_data_valid, i_data_we, i_invtlb_valid;
    logic i_tlb_we, i_tlbsrch_valid, i_icache_addr_ok, i_dcache_addr_ok;
    logic i_icache_data_ok = 1'b0;
    logic i_dcache_data_ok = 1'b0;
    logic [1:0] i_datf, i_datm, i_plv, i_data_size;
    logic [9:0] i_asid, i_invtlb_asid;
    logic [3:0] i_data_wstrb;
    logic [4:0] i_invtlb_op;
    logic [18:0] i_tlbsrch_vppn;
    logic [31:0] i_fetch_va, i_data_va, i_data_wdata, i_invtlb_va;
    logic [31:0] i_dcache_rdata = '0;
    logic [63:0] i_icache_rdata = '0;
    logic [`TLB_IDX_W-1:0] i_tlb_w_index, i_tlb_r_index;
    dmw_t i_dmw0, i_dmw1;
    tlb_entry_t i_tlb_w_entry;
    logic o_fetch_addr_ok, o_fetch_double, o_fetch_data_ok, o_fetch_tlbr, o_fetch_pif;
    logic o_fetch_ppi, o_data_addr_ok, o_data_data_ok, o_data_tlbr, o_data_pil;
    logic o_data_pis, o_data_ppi, o_data_pme, o_tlbsrch_found, o_icache_req;
    logic o_icache_uncached, o_dcache_req, o_dcache_wr, o_dcache_uncached;
    logic [63:0] o_fetch_rdata;
    logic [31:0] o_data_rdata, o_icache_addr, o_dcache_addr, o_dcache_wdata;
    logic [1:0] o_dcache_size;
    logic [3:0] o_dcache_wstrb;
    logic [`TLB_IDX_W-1:0] o_tlbsrch_index;
    tlb_entry_t o_tlb_r_entry;
    integer seed = 32'h0f855d1b;

    mmu dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // cache models accept at once and answer one cycle later
    assign i_icache_addr_ok = o_icache_req;
    assign i_dcache_addr_ok = o_dcache_req;

    always @(posedge clk) begin
        if (!i_rst_n) begin
            i_icache_data_ok <= 1'b0;
            i_dcache_data_ok <= 1'b0;
        end else begin
            i_icache_data_ok <= o_icache_req && i_icache_addr_ok;
            i_dcache_data_ok <= o_dcache_req && i_dcache_addr_ok;
        end
        i_icache_rdata <= {~o_icache_addr, o_icache_addr};
        i_dcache_rdata <= o_dcache_addr ^ 32'hdead_beef;
    end

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            fail_now($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_flags(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) begin
            fail_now($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_entry(input string name, input tlb_entry_t exp, input tlb_entry_t act);
        if (exp !== act) begin
            fail_now($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_srch(input string name, input logic exp_found,
                              input logic [`TLB_IDX_W-1:0] exp_idx);
        if (exp_found !== o_tlbsrch_found || (exp_found && exp_idx !== o_tlbsrch_index)) begin
            fail_now($sformatf("CHECK FAILED %s: expected %b/%0d, actual %b/%0d", name,
                               exp_found, exp_idx, o_tlbsrch_found, o_tlbsrch_index));
        end
    endtask

    task automatic check_store(input string name, input logic exp_wr,
                               input logic [1:0] exp_size, input logic [3:0] exp_wstrb,
                               input logic [31:0] exp_wdata);
        if ({exp_wr, exp_size, exp_wstrb, exp_wdata}
                !== {o_dcache_wr, o_dcache_size, o_dcache_wstrb, o_dcache_wdata}) begin
            fail_now($sformatf("CHECK FAILED %s: expected %b/%0d/%b/%h, actual %b/%0d/%b/%h",
                               name, exp_wr, exp_size, exp_wstrb, exp_wdata, o_dcache_wr,
                               o_dcache_size, o_dcache_wstrb, o_dcache_wdata));
        end
    endtask

    // waits at falling edges for a strobe, giving up after TIMEOUT cycles
    task automatic wait_strobe(input logic is_data, input logic addr_phase, input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (!(addr_phase ? (is_data ? o_data_addr_ok : o_fetch_addr_ok)
                            : (is_data ? o_data_data_ok : o_fetch_data_ok))) begin
            n++;
            if (n > TIMEOUT) begin
                fail_now($sformatf("%s: timed out waiting for the cache response", name));
            end
            @(negedge clk);
        end
    endtask

    task automatic load_entries();
        for (int k = 0; k < 4; k++) begin
            @(posedge clk);
            i_tlb_we      <= 1'b1;
            i_tlb_w_index <= k[`TLB_IDX_W-1:0];
            i_tlb_w_entry <= PRELOAD[k];
        end
        @(posedge clk);
        i_tlb_we <= 1'b0;
    endtask

    task automatic search(input logic [18:0] vppn, input logic [9:0] asid);
        @(posedge clk);
        i_tlbsrch_valid <= 1'b1;
        i_tlbsrch_vppn  <= vppn;
        i_asid          <= asid;
        @(negedge clk);
    endtask

    // INVTLB rule for one entry, invalidating with asid 5 and the vppn of entry 0
    function automatic logic inv_kills(input logic [4:0] op, input tlb_entry_t e);
        logic asid_eq;
        logic vppn_eq;
        asid_eq = e.asid == 10'd5;
        vppn_eq = e.vppn == PRELOAD[0].vppn;
        case (op)
            5'd0, 5'd1: return 1'b1;
            5'd2:       return e.g;
            5'd3:       return !e.g;
            5'd4:       return !e.g && asid_eq;
            5'd5:       return !e.g && asid_eq && vppn_eq;
            default:    return (e.g || asid_eq) && vppn_eq;
        endcase
    endfunction

    task automatic run_case(input case_t c);
        string       name;
        logic        is_data;
        logic [7:0]  act;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
        name    = $sformatf("%0s", c.name);
        is_data = c.mode[1];
        wstrb   = 4'($random(seed)) | 4'b0001;
        wdata   = $random(seed);
        @(posedge clk);
        i_da          <= c.mode[3];
        i_dmw0        <= c.mode[2] ? DMW_A : '0;
        i_dmw1        <= c.mode[2] ? DMW_B : '0;
        i_plv         <= c.plv;
        i_asid        <= c.asid;
        i_fetch_valid <= !is_data;
        i_fetch_va    <= c.va;
        i_data_valid  <= is_data;
        i_data_va     <= c.va;
        i_data_we     <= c.mode[0];
        i_data_wstrb  <= wstrb;
        i_data_wdata  <= wdata;
        wait_strobe(is_data, 1'b1, name);
        if (is_data) begin
            act = {o_dcache_uncached, 1'b0, o_data_tlbr, 1'b0, o_data_pil, o_data_pis,
                   o_data_ppi, o_data_pme};
        end else begin
            act = {o_icache_uncached, o_fetch_double, o_fetch_tlbr, o_fetch_pif, 2'b00,
                   o_fetch_ppi, 1'b0};
        end
        if (c.flags[5]) begin
            act[7] = c.flags[7];                // a refill has no memory type
        end
        check_flags(name, c.flags, act);
        if (c.chk_pa) begin
            check_addr(name, c.pa, is_data ? o_dcache_addr : o_icache_addr);
        end
        if (is_data) begin
            check_store(name, c.mode[0], i_data_size, wstrb, wdata);
        end
        @(posedge clk);
        i_fetch_valid <= 1'b0;
        i_data_valid  <= 1'b0;
        wait_strobe(is_data, 1'b0, name);
        if (c.chk_pa && is_data) begin
            check_addr(name, c.pa ^ 32'hdead_beef, o_data_rdata);
        end else if (c.chk_pa) begin
            check_addr(name, c.pa, o_fetch_rdata[31:0]);
            check_addr(name, ~c.pa, o_fetch_rdata[63:32]);
        end
    endtask

    initial begin
        {i_da, i_fetch_valid, i_data_valid, i_data_we, i_invtlb_valid} = '0;
        {i_tlb_we, i_tlbsrch_valid, i_plv, i_asid, i_invtlb_asid, i_invtlb_op} = '0;
        {i_fetch_va, i_data_va, i_data_wdata, i_invtlb_va, i_tlbsrch_vppn} = '0;
        {i_tlb_w_index, i_tlb_r_index, i_dmw0, i_dmw1, i_tlb_w_entry} = '0;
        i_datf       = 2'd1;                    // direct-mode fetches are cached
        i_datm       = 2'd0;
        i_data_size  = 2'd2;
        i_data_wstrb = 4'hf;
        i_rst_n      = 1'b0;
        repeat (10) @(posedge clk);
        i_rst_n <= 1'b1;
        load_entries();
        for (int k = 0; k < 4; k++) begin
            @(posedge clk);
            i_tlb_r_index <= k[`TLB_IDX_W-1:0];
            @(negedge clk);
            check_entry($sformatf("read_%0d", k), PRELOAD[k], o_tlb_r_entry);
            search(PRELOAD[k].vppn, PRELOAD[k].asid);
            check_srch($sformatf("srch_hit_%0d", k), 1'b1, k[`TLB_IDX_W-1:0]);
        end
        search(19'h7ffff, 10'd5);
        check_srch("srch_miss", 1'b0, '0);
        @(posedge clk);
        i_tlbsrch_valid <= 1'b0;
        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(CASES[i]);
        end
        for (int op = 0; op <= 6; op++) begin
            load_entries();
            i_invtlb_valid <= 1'b1;
            i_invtlb_op    <= op[4:0];
            i_invtlb_asid  <= 10'd5;
            i_invtlb_va    <= {PRELOAD[0].vppn, 13'h0};
            @(posedge clk);
            i_invtlb_valid <= 1'b0;
            for (int k = 0; k < 4; k++) begin
                search(PRELOAD[k].vppn, PRELOAD[k].asid);
                check_srch($sformatf("invtlb_op%0d_entry%0d", op, k),
                           !inv_kills(op[4:0], PRELOAD[k]), k[`TLB_IDX_W-1:0]);
            end
            @(posedge clk);
            i_tlbsrch_valid <= 1'b0;
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule
